// File: tb.f
+incdir+tb
verilog/pcie_core_pkg.sv
verilog/pcie_core_if.sv
verilog/cq_request_decoder.sv
verilog/bar_register_file.sv
verilog/cc_completion_encoder.sv
verilog/example_core.sv
verilog/fpga_core.sv
tb/tb_fpga_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the PCIe core testbench with Verilator and run it.
# The result is decided by searching the log for the fail message.

LOG=sim.log

verilator --binary --timing --assert --top-module tb_fpga_core -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation run did not complete"; exit 1; }

cat "$LOG"
grep -q "Test failed" "$LOG" && { echo "Simulation reported errors"; exit 1; } || exit 0

// File: tb/tb_vectors.svh
    // ==============================
    // Request table for the PCIe core testbench
    // One entry per test with its expected completion and LED state
    // ==============================

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

    typedef struct {
        string       name;
        logic [3:0]  req_type;
        logic [2:0]  bar_id;
        logic [15:0] addr;          // Byte address inside BAR0
        logic [3:0]  byte_en;
        logic [31:0] wdata;
        logic [7:0]  tag;
        logic [3:0]  sw_val;
        logic        cpl_exp;
        logic [31:0] exp_data;
        logic [2:0]  exp_led;
        logic        back_to_back;  // Next request follows without waiting
    } test_vector_t;

    test_vector_t vectors [$];

    task automatic load_vectors();
        vectors.push_back(test_vector_t'{"read_id", MEM_READ, 3'd0, 16'h0000, 4'hF,
            32'h0, 8'h11, 4'h0, 1'b1, CORE_ID, 3'd0, 1'b0});
        vectors.push_back(test_vector_t'{"write_scratch", MEM_WRITE, 3'd0, 16'h0004, 4'hF,
            32'h1234_5678, 8'h12, 4'h0, 1'b0, 32'h0, 3'd0, 1'b0});
        // Lanes 0 and 2 only, so the scratch becomes 12BB_56DD
        vectors.push_back(test_vector_t'{"write_scratch_lanes", MEM_WRITE, 3'd0, 16'h0004, 4'h5,
            32'hAABB_CCDD, 8'h13, 4'h0, 1'b0, 32'h0, 3'd0, 1'b0});
        vectors.push_back(test_vector_t'{"read_scratch", MEM_READ, 3'd0, 16'h0004, 4'hF,
            32'h0, 8'h14, 4'h0, 1'b1, 32'h12BB_56DD, 3'd0, 1'b0});
        vectors.push_back(test_vector_t'{"write_led", MEM_WRITE, 3'd0, 16'h0008, 4'hF,
            32'h0000_00F5, 8'h15, 4'h0, 1'b0, 32'h0, 3'd5, 1'b0});
        vectors.push_back(test_vector_t'{"read_led", MEM_READ, 3'd0, 16'h0008, 4'hF,
            32'h0, 8'h16, 4'h0, 1'b1, 32'h0000_00F5, 3'd5, 1'b0});
        vectors.push_back(test_vector_t'{"read_switch", MEM_READ, 3'd0, 16'h000C, 4'hF,
            32'h0, 8'h17, 4'hA, 1'b1, 32'h0000_000A, 3'd5, 1'b0});
        // One aperture above the scratch register
        vectors.push_back(test_vector_t'{"read_wrap", MEM_READ, 3'd0, 16'h1004, 4'hF,
            32'h0, 8'h18, 4'hA, 1'b1, 32'h12BB_56DD, 3'd5, 1'b0});
        vectors.push_back(test_vector_t'{"read_unmapped", MEM_READ, 3'd0, 16'h0040, 4'hF,
            32'h0, 8'h19, 4'hA, 1'b1, 32'h0, 3'd5, 1'b0});
        vectors.push_back(test_vector_t'{"bad_type", 4'h2, 3'd0, 16'h0004, 4'hF,
            32'h0, 8'h1A, 4'hA, 1'b0, 32'h0, 3'd5, 1'b0});
        vectors.push_back(test_vector_t'{"bad_bar_write", MEM_WRITE, 3'd2, 16'h0004, 4'hF,
            32'hFFFF_FFFF, 8'h1B, 4'hA, 1'b0, 32'h0, 3'd5, 1'b0});
        // Three BAR0 writes so far
        vectors.push_back(test_vector_t'{"read_write_count", MEM_READ, 3'd0, 16'h0010, 4'hF,
            32'h0, 8'h1C, 4'hA, 1'b1, 32'd3, 3'd5, 1'b0});
        vectors.push_back(test_vector_t'{"burst_id", MEM_READ, 3'd0, 16'h0000, 4'hF,
            32'h0, 8'h20, 4'h3, 1'b1, CORE_ID, 3'd5, 1'b1});
        vectors.push_back(test_vector_t'{"burst_scratch", MEM_READ, 3'd0, 16'h0004, 4'hF,
            32'h0, 8'h21, 4'h3, 1'b1, 32'h12BB_56DD, 3'd5, 1'b1});
        vectors.push_back(test_vector_t'{"burst_switch", MEM_READ, 3'd0, 16'h000C, 4'hF,
            32'h0, 8'h22, 4'h3, 1'b1, 32'h0000_0003, 3'd5, 1'b1});
        vectors.push_back(test_vector_t'{"burst_count", MEM_READ, 3'd0, 16'h0010, 4'hF,
            32'h0, 8'h23, 4'h3, 1'b1, 32'd3, 3'd5, 1'b0});
    endtask

`endif

// File: tb/tb_fpga_core.sv
// ==============================
// Testbench for the PCIe endpoint core
// Sends CQ requests from a table and checks CC completions,
// LED state and the unsupported-request pulse
// ==============================

`timescale 1ns/1ps
`default_nettype none

module tb_fpga_core import pcie_core_pkg::*; ();

    logic                       clk;
    logic                       arst_n;
    logic [3:0]                 sw;
    wire  [2:0]                 led;
    logic [AXIS_DATA_WIDTH-1:0] s_axis_cq_tdata;
    logic [AXIS_KEEP_WIDTH-1:0] s_axis_cq_tkeep;
    logic                       s_axis_cq_tvalid;
    wire                        s_axis_cq_tready;
    logic                       s_axis_cq_tlast;
    logic [3:0]                 s_axis_cq_tuser;
    wire  [AXIS_DATA_WIDTH-1:0] m_axis_cc_tdata;
    wire  [AXIS_KEEP_WIDTH-1:0] m_axis_cc_tkeep;
    wire                        m_axis_cc_tvalid;
    logic                       m_axis_cc_tready;
    wire                        m_axis_cc_tlast;
    wire                        status_error_uncor;

    int error_count;
    int test_errors [];
    int exp_idx_q [$];
    int unreported [$];

    `include "tb_vectors.svh"

    fpga_core #(
        .BAR0_APERTURE(12)
    ) uut (
        .clk(clk),
        .arst_n(arst_n),
        .sw(sw),
        .led(led),
        .s_axis_cq_tdata(s_axis_cq_tdata),
        .s_axis_cq_tkeep(s_axis_cq_tkeep),
        .s_axis_cq_tvalid(s_axis_cq_tvalid),
        .s_axis_cq_tready(s_axis_cq_tready),
        .s_axis_cq_tlast(s_axis_cq_tlast),
        .s_axis_cq_tuser(s_axis_cq_tuser),
        .m_axis_cc_tdata(m_axis_cc_tdata),
        .m_axis_cc_tkeep(m_axis_cc_tkeep),
        .m_axis_cc_tvalid(m_axis_cc_tvalid),
        .m_axis_cc_tready(m_axis_cc_tready),
        .m_axis_cc_tlast(m_axis_cc_tlast),
        .status_error_uncor(status_error_uncor)
    );

    always #2 clk = ~clk;

    // Descriptor in the vendor CQ layout for a one-dword request
    function automatic logic [127:0] build_descriptor(input test_vector_t v);
        logic [127:0] d;
        d = '0;
        d[63:2] = 62'(v.addr >> 2);
        d[74:64] = 11'd1;
        d[78:75] = v.req_type;
        d[103:96] = v.tag;
        d[114:112] = v.bar_id;
        return d;
    endfunction

    // Successful one-dword completion with the read data in the top dword
    function automatic logic [127:0] expected_beat(input test_vector_t v);
        logic [127:0] b;
        b = '0;
        b[6:0] = v.addr[6:0];
        b[28:16] = 13'd4;
        b[42:32] = 11'd1;
        b[71:64] = v.tag;
        b[127:96] = v.exp_data;
        return b;
    endfunction

    function automatic void note_error(input int idx);
        error_count++;
        test_errors[idx]++;
    endfunction

    task automatic report_test(input int idx);
        if (test_errors[idx] == 0) begin
            $display("test %0d %s: ok", idx, vectors[idx].name);
        end else begin
            $display("test %0d %s: %0d error(s)", idx, vectors[idx].name, test_errors[idx]);
        end
    endtask

    // Drive one CQ beat and hold it until the core takes it
    task automatic send_beat(
        input logic [127:0] data,
        input logic [3:0]   keep,
        input logic         last
    );
        s_axis_cq_tdata = data;
        s_axis_cq_tkeep = keep;
        s_axis_cq_tlast = last;
        s_axis_cq_tvalid = 1'b1;
        @(posedge clk);
        while (!s_axis_cq_tready) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic send_request(input int idx);
        test_vector_t v;
        logic         supported;
        v = vectors[idx];
        supported = (v.req_type == MEM_READ || v.req_type == MEM_WRITE) && v.bar_id == 3'd0;
        s_axis_cq_tuser = v.byte_en;
        send_beat(build_descriptor(v), 4'hF, v.req_type != MEM_WRITE);
        assert (status_error_uncor == !supported) else begin
            $display("[FAIL] %s: status_error_uncor expected %b actual %b",
                     v.name, !supported, status_error_uncor);
            note_error(idx);
        end
        // Writes carry their payload dword in a second beat
        if (v.req_type == MEM_WRITE) begin
            send_beat({96'd0, v.wdata}, 4'h1, 1'b1);
        end
        s_axis_cq_tvalid = 1'b0;
    endtask

    // Takes CC beats in order and checks them against the expected queue
    task automatic monitor_cc();
        logic         held_valid;
        logic [127:0] held_data;
        logic [127:0] exp;
        int           idx;
        held_valid = 1'b0;
        held_data = '0;
        forever begin
            @(posedge clk);
            if (held_valid && exp_idx_q.size() != 0) begin
                assert (m_axis_cc_tvalid && m_axis_cc_tdata == held_data) else begin
                    $display("[FAIL] %s: stalled CC beat expected 1/%h actual %b/%h",
                             vectors[exp_idx_q[0]].name, held_data, m_axis_cc_tvalid,
                             m_axis_cc_tdata);
                    note_error(exp_idx_q[0]);
                end
            end
            if (m_axis_cc_tvalid && m_axis_cc_tready) begin
                assert (exp_idx_q.size() != 0) else begin
                    $display("Extra completion with tag %h arrived while no read was outstanding",
                             m_axis_cc_tdata[71:64]);
                    error_count++;
                end
                if (exp_idx_q.size() != 0) begin
                    idx = exp_idx_q.pop_front();
                    exp = expected_beat(vectors[idx]);
                    assert (m_axis_cc_tdata == exp) else begin
                        $display("[FAIL] %s: completion expected %h actual %h",
                                 vectors[idx].name, exp, m_axis_cc_tdata);
                        note_error(idx);
                    end
                    assert (m_axis_cc_tkeep == 4'hF && m_axis_cc_tlast == 1'b1) else begin
                        $display("[FAIL] %s: keep/last expected f/1 actual %h/%b",
                                 vectors[idx].name, m_axis_cc_tkeep, m_axis_cc_tlast);
                        note_error(idx);
                    end
                end
            end
            held_valid = m_axis_cc_tvalid && !m_axis_cc_tready;
            held_data = m_axis_cc_tdata;
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int passed;
        clk = 1'b0;
        arst_n = 1'b0;
        sw = 4'h0;
        s_axis_cq_tdata = '0;
        s_axis_cq_tkeep = '0;
        s_axis_cq_tvalid = 1'b0;
        s_axis_cq_tlast = 1'b0;
        s_axis_cq_tuser = 4'h0;
        error_count = 0;
        passed = 0;
        load_vectors();
        test_errors = new[vectors.size()];
        fork
            monitor_cc();
        join_none
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        assert (!m_axis_cc_tvalid && !status_error_uncor && led == 3'd0) else begin
            $display("Outputs were not in their reset state after reset");
            error_count++;
        end
        for (int i = 0; i < vectors.size(); i++) begin
            sw = vectors[i].sw_val;
            if (vectors[i].cpl_exp) begin
                exp_idx_q.push_back(i);
            end
            send_request(i);
            unreported.push_back(i);
            if (!vectors[i].back_to_back) begin
                while (exp_idx_q.size() != 0) begin
                    @(negedge clk);
                end
                // A write lands one clock after its last beat when the pipeline is empty
                @(posedge clk);
                @(negedge clk);
                assert (!status_error_uncor) else begin
                    $display("status_error_uncor stayed high for more than one cycle");
                    note_error(i);
                end
            end
            assert (led == vectors[i].exp_led) else begin
                $display("[FAIL] %s: led expected %h actual %h",
                         vectors[i].name, vectors[i].exp_led, led);
                note_error(i);
            end
            if (!vectors[i].back_to_back) begin
                while (unreported.size() != 0) begin
                    report_test(unreported.pop_front());
                end
            end
        end
        // Give a stray completion time to show up
        repeat (8) @(negedge clk);
        foreach (test_errors[i]) begin
            if (test_errors[i] == 0) begin
                passed++;
            end
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 vectors.size(), passed, vectors.size() - passed, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Random CC back-pressure with ready high about three cycles in four
    initial begin
        void'($urandom(96296));
        m_axis_cc_tready = 1'b0;
        forever begin
            @(negedge clk);
            m_axis_cc_tready = ($urandom % 4) != 0;
        end
    end

    // Watchdog allows 40 cycles per table entry after reset
    initial begin
        @(posedge arst_n);
        repeat (vectors.size() * 40) @(posedge clk);
        $display("Watchdog timeout with %0d completion(s) still missing", exp_idx_q.size());
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/fpga_core.sv
// ==============================
// FPGA core top level
// PCIe completer streams and GPIO around the example core
// ==============================

`timescale 1ns/1ps
`default_nettype none

module fpga_core import pcie_core_pkg::*; #(
    parameter int BAR0_APERTURE = 12
) (
    // Core clock, reset is asynchronous and active low
    input  wire                        clk,
    input  wire                        arst_n,

    // GPIO
    input  wire [3:0]                  sw,
    output wire [2:0]                  led,

    // Completer request stream
    input  wire [AXIS_DATA_WIDTH-1:0]  s_axis_cq_tdata,
    input  wire [AXIS_KEEP_WIDTH-1:0]  s_axis_cq_tkeep,
    input  wire                        s_axis_cq_tvalid,
    output wire                        s_axis_cq_tready,
    input  wire                        s_axis_cq_tlast,
    input  wire [3:0]                  s_axis_cq_tuser,

    // Completer completion stream
    output wire [AXIS_DATA_WIDTH-1:0]  m_axis_cc_tdata,
    output wire [AXIS_KEEP_WIDTH-1:0]  m_axis_cc_tkeep,
    output wire                        m_axis_cc_tvalid,
    input  wire                        m_axis_cc_tready,
    output wire                        m_axis_cc_tlast,

    output wire                        status_error_uncor
);

    example_core #(
        .BAR0_APERTURE(BAR0_APERTURE)
    ) example_core_inst (
        .clk(clk),
        .arst_n(arst_n),
        .sw(sw),
        .led(led),
        .s_axis_cq_tdata(s_axis_cq_tdata),
        .s_axis_cq_tkeep(s_axis_cq_tkeep),
        .s_axis_cq_tvalid(s_axis_cq_tvalid),
        .s_axis_cq_tready(s_axis_cq_tready),
        .s_axis_cq_tlast(s_axis_cq_tlast),
        .s_axis_cq_tuser(s_axis_cq_tuser),
        .m_axis_cc_tdata(m_axis_cc_tdata),
        .m_axis_cc_tkeep(m_axis_cc_tkeep),
        .m_axis_cc_tvalid(m_axis_cc_tvalid),
        .m_axis_cc_tready(m_axis_cc_tready),
        .m_axis_cc_tlast(m_axis_cc_tlast),
        .status_error_uncor(status_error_uncor)
    );

endmodule

`default_nettype wire

// File: verilog/example_core.sv
// ==============================
// PCIe example core
// CQ decoder, BAR0 registers and CC encoder in a chain
// ==============================

`timescale 1ns/1ps
`default_nettype none

module example_core import pcie_core_pkg::*; #(
    parameter int BAR0_APERTURE = 12
) (
    input  wire                        clk,
    input  wire                        arst_n,

    input  wire [3:0]                  sw,
    output wire [2:0]                  led,

    input  wire [AXIS_DATA_WIDTH-1:0]  s_axis_cq_tdata,
    input  wire [AXIS_KEEP_WIDTH-1:0]  s_axis_cq_tkeep,
    input  wire                        s_axis_cq_tvalid,
    output wire                        s_axis_cq_tready,
    input  wire                        s_axis_cq_tlast,
    input  wire [3:0]                  s_axis_cq_tuser,

    output wire [AXIS_DATA_WIDTH-1:0]  m_axis_cc_tdata,
    output wire [AXIS_KEEP_WIDTH-1:0]  m_axis_cc_tkeep,
    output wire                        m_axis_cc_tvalid,
    input  wire                        m_axis_cc_tready,
    output wire                        m_axis_cc_tlast,

    output wire                        status_error_uncor
);

    pcie_req_if req_link ();
    pcie_cpl_if cpl_link ();

    cq_request_decoder #(
        .BAR0_APERTURE(BAR0_APERTURE)
    ) cq_request_decoder_inst (
        .clk(clk),
        .arst_n(arst_n),
        .s_axis_cq_tdata(s_axis_cq_tdata),
        .s_axis_cq_tkeep(s_axis_cq_tkeep),
        .s_axis_cq_tvalid(s_axis_cq_tvalid),
        .s_axis_cq_tready(s_axis_cq_tready),
        .s_axis_cq_tlast(s_axis_cq_tlast),
        .s_axis_cq_tuser(s_axis_cq_tuser),
        .req(req_link.source),
        .status_error_uncor(status_error_uncor)
    );

    bar_register_file bar_register_file_inst (
        .clk(clk),
        .arst_n(arst_n),
        .sw(sw),
        .led(led),
        .req(req_link.sink),
        .cpl(cpl_link.source)
    );

    cc_completion_encoder cc_completion_encoder_inst (
        .clk(clk),
        .arst_n(arst_n),
        .cpl(cpl_link.sink),
        .m_axis_cc_tdata(m_axis_cc_tdata),
        .m_axis_cc_tkeep(m_axis_cc_tkeep),
        .m_axis_cc_tvalid(m_axis_cc_tvalid),
        .m_axis_cc_tready(m_axis_cc_tready),
        .m_axis_cc_tlast(m_axis_cc_tlast)
    );

endmodule

`default_nettype wire

// File: verilog/cc_completion_encoder.sv
// ==============================
// CC completion encoder
// Packs a read completion into one 128-bit CC beat and holds
// it until the stream takes it
// ==============================

`timescale 1ns/1ps
`default_nettype none

module cc_completion_encoder import pcie_core_pkg::*; (
    input  wire                        clk,
    input  wire                        arst_n,

    pcie_cpl_if.sink                   cpl,

    output logic [AXIS_DATA_WIDTH-1:0] m_axis_cc_tdata,
    output logic [AXIS_KEEP_WIDTH-1:0] m_axis_cc_tkeep,
    output logic                       m_axis_cc_tvalid,
    input  wire                        m_axis_cc_tready,
    output logic                       m_axis_cc_tlast
);

    logic [AXIS_DATA_WIDTH-1:0] beat_next;
    logic                       load;

    // The slot is free when empty or when the current beat leaves now
    assign cpl.ready = !m_axis_cc_tvalid || m_axis_cc_tready;
    assign load = cpl.valid && cpl.ready;

    // Every completion is a single dword, so keep and last are fixed
    assign m_axis_cc_tkeep = {AXIS_KEEP_WIDTH{1'b1}};
    assign m_axis_cc_tlast = 1'b1;

    always_comb begin
        beat_next = '0;
        beat_next[CPL_LADDR_MSB:CPL_LADDR_LSB] = cpl.lower_addr;
        beat_next[CPL_BCNT_MSB:CPL_BCNT_LSB] = 13'd4;
        beat_next[CPL_DWCNT_MSB:CPL_DWCNT_LSB] = 11'd1;
        beat_next[CPL_TAG_MSB:CPL_TAG_LSB] = cpl.tag;
        beat_next[CPL_STATUS_MSB:CPL_STATUS_LSB] = CPL_STATUS_SC;
        beat_next[CPL_DATA_MSB:CPL_DATA_LSB] = cpl.data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_axis_cc_tvalid <= 1'b0;
        end else if (load) begin
            m_axis_cc_tvalid <= 1'b1;
        end else if (m_axis_cc_tready) begin
            m_axis_cc_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            m_axis_cc_tdata <= beat_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/bar_register_file.sv
// ==============================
// BAR0 register file
// ID, scratch, LED, switch and write counter registers
// Reads return a completion to the CC encoder
// ==============================

`timescale 1ns/1ps
`default_nettype none

module bar_register_file import pcie_core_pkg::*; (
    input  wire        clk,
    input  wire        arst_n,

    input  wire [3:0]  sw,
    output logic [2:0] led,

    pcie_req_if.sink   req,
    pcie_cpl_if.source cpl
);

    logic [31:0]         scratch_reg;
    logic [31:0]         led_reg;
    logic [31:0]         write_count;
    logic [31:0]         read_data;
    logic [REG_ADDR_WIDTH-1:0] byte_off;
    logic                accept;

    // Merge new bytes into an old value, one lane per enable bit
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [3:0]  be
    );
        logic [31:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign byte_off = {req.addr[REG_ADDR_WIDTH-3:0], 2'b00};
    assign req.ready = !cpl.valid || cpl.ready;
    assign accept = req.valid && req.ready;
    assign led = led_reg[2:0];

    // Read mux, unmapped offsets read as zero
    always_comb begin
        case (byte_off)
            REG_ID:          read_data = CORE_ID;
            REG_SCRATCH:     read_data = scratch_reg;
            REG_LED:         read_data = led_reg;
            REG_SWITCH:      read_data = {28'd0, sw};
            REG_WRITE_COUNT: read_data = write_count;
            default:         read_data = 32'd0;
        endcase
    end

    // ==============================
    // Registers and completion slot
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scratch_reg <= 32'd0;
            led_reg <= 32'd0;
            write_count <= 32'd0;
            cpl.valid <= 1'b0;
        end else begin
            if (cpl.ready) begin
                cpl.valid <= 1'b0;
            end
            if (accept && req.is_write) begin
                // Every accepted write counts, mapped or not
                write_count <= write_count + 32'd1;
                case (byte_off)
                    REG_SCRATCH: scratch_reg <= merge_bytes(scratch_reg, req.data, req.byte_en);
                    REG_LED:     led_reg <= merge_bytes(led_reg, req.data, req.byte_en);
                    default:     ;
                endcase
            end
            if (accept && !req.is_write) begin
                cpl.valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !req.is_write) begin
            cpl.data <= read_data;
            cpl.tag <= req.tag;
            cpl.lower_addr <= byte_off[6:0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/cq_request_decoder.sv
// ==============================
// CQ request decoder
// Turns BAR0 memory reads and writes on the CQ stream into
// register requests and discards everything else
// ==============================

`timescale 1ns/1ps
`default_nettype none

module cq_request_decoder import pcie_core_pkg::*; #(
    parameter int BAR0_APERTURE = 12
) (
    input  wire                        clk,
    input  wire                        arst_n,

    input  wire [AXIS_DATA_WIDTH-1:0]  s_axis_cq_tdata,
    input  wire [AXIS_KEEP_WIDTH-1:0]  s_axis_cq_tkeep,
    input  wire                        s_axis_cq_tvalid,
    output logic                       s_axis_cq_tready,
    input  wire                        s_axis_cq_tlast,
    input  wire [3:0]                  s_axis_cq_tuser,

    pcie_req_if.source                 req,

    output logic                       status_error_uncor
);

    // Aperture counts byte address bits, the slot holds a dword address
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_MASK =
        REG_ADDR_WIDTH'((1 << (BAR0_APERTURE - 2)) - 1);

    cq_state_t                 state;
    req_type_t                 desc_type;
    logic                      desc_ok;
    logic                      beat;
    logic [REG_ADDR_WIDTH-1:0] desc_addr;

    assign desc_type = req_type_t'(s_axis_cq_tdata[DESC_TYPE_MSB:DESC_TYPE_LSB]);
    assign desc_addr = s_axis_cq_tdata[DESC_ADDR_LSB +: REG_ADDR_WIDTH] & ADDR_MASK;
    assign desc_ok   = (desc_type == MEM_READ || desc_type == MEM_WRITE) &&
                       s_axis_cq_tdata[DESC_BAR_MSB:DESC_BAR_LSB] == 3'd0;

    // The slot accepts a new beat once it is empty or being emptied
    assign s_axis_cq_tready = !req.valid || req.ready;
    assign beat = s_axis_cq_tvalid && s_axis_cq_tready;

    // ==============================
    // Control state
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            req.valid <= 1'b0;
            status_error_uncor <= 1'b0;
        end else begin
            status_error_uncor <= 1'b0;
            if (req.ready) begin
                req.valid <= 1'b0;
            end
            if (beat) begin
                case (state)
                    IDLE: begin
                        if (!desc_ok) begin
                            status_error_uncor <= 1'b1;
                            state <= s_axis_cq_tlast ? IDLE : DROP;
                        end else if (desc_type == MEM_READ) begin
                            req.valid <= 1'b1;
                            state <= s_axis_cq_tlast ? IDLE : DROP;
                        end else if (!s_axis_cq_tlast) begin
                            // Write descriptor, the payload dword comes next
                            state <= PAYLOAD;
                        end
                    end
                    PAYLOAD: begin
                        req.valid <= 1'b1;
                        state <= s_axis_cq_tlast ? IDLE : DROP;
                    end
                    default: begin
                        if (s_axis_cq_tlast) begin
                            state <= IDLE;
                        end
                    end
                endcase
            end
        end
    end

    // Request fields are captured from the descriptor and the payload beat
    always_ff @(posedge clk) begin
        if (beat && state == IDLE) begin
            req.is_write <= (desc_type == MEM_WRITE);
            req.addr <= desc_addr;
            req.tag <= s_axis_cq_tdata[DESC_TAG_MSB:DESC_TAG_LSB];
            req.byte_en <= s_axis_cq_tuser;
        end
        if (beat && state == PAYLOAD) begin
            req.data <= s_axis_cq_tdata[31:0];
            // A payload beat without its first dword writes nothing
            req.byte_en <= req.byte_en & {4{s_axis_cq_tkeep[0]}};
        end
    end

endmodule

`default_nettype wire

// File: verilog/pcie_core_if.sv
// ==============================
// Internal request and completion links
// Both use a valid/ready handshake
// ==============================

`timescale 1ns/1ps
`default_nettype none

// Decoded register request from the CQ decoder to the register file
interface pcie_req_if import pcie_core_pkg::*; ();

    logic                      valid;
    logic                      ready;
    logic                      is_write;
    // Dword address, already masked to the BAR0 aperture
    logic [REG_ADDR_WIDTH-1:0] addr;
    logic [31:0]               data;
    logic [3:0]                byte_en;
    logic [TAG_WIDTH-1:0]      tag;

    modport source (
        output valid, is_write, addr, data, byte_en, tag,
        input  ready
    );

    modport sink (
        input  valid, is_write, addr, data, byte_en, tag,
        output ready
    );

endinterface

// Read completion from the register file to the CC encoder
interface pcie_cpl_if import pcie_core_pkg::*; ();

    logic                 valid;
    logic                 ready;
    logic [TAG_WIDTH-1:0] tag;
    logic [6:0]           lower_addr;
    logic [31:0]          data;

    modport source (
        output valid, tag, lower_addr, data,
        input  ready
    );

    modport sink (
        input  valid, tag, lower_addr, data,
        output ready
    );

endinterface

`default_nettype wire

// File: verilog/pcie_core_pkg.sv
// ==============================
// PCIe endpoint core package
// Stream widths, descriptor and completion field positions,
// opcodes, decoder states and the BAR0 register map
// ==============================

`default_nettype none

package pcie_core_pkg;

    localparam int AXIS_DATA_WIDTH = 128;
    localparam int AXIS_KEEP_WIDTH = 4;
    localparam int TAG_WIDTH = 8;
    localparam int REG_ADDR_WIDTH = 16;

    // ==============================
    // CQ descriptor fields
    // ==============================
    localparam int DESC_ADDR_LSB = 2;
    localparam int DESC_ADDR_MSB = 63;
    localparam int DESC_DWCNT_LSB = 64;
    localparam int DESC_DWCNT_MSB = 74;
    localparam int DESC_TYPE_LSB = 75;
    localparam int DESC_TYPE_MSB = 78;
    localparam int DESC_TAG_LSB = 96;
    localparam int DESC_TAG_MSB = 103;
    localparam int DESC_BAR_LSB = 112;
    localparam int DESC_BAR_MSB = 114;

    // ==============================
    // CC completion fields
    // ==============================
    localparam int CPL_LADDR_LSB = 0;
    localparam int CPL_LADDR_MSB = 6;
    localparam int CPL_BCNT_LSB = 16;
    localparam int CPL_BCNT_MSB = 28;
    localparam int CPL_DWCNT_LSB = 32;
    localparam int CPL_DWCNT_MSB = 42;
    localparam int CPL_TAG_LSB = 64;
    localparam int CPL_TAG_MSB = 71;
    localparam int CPL_STATUS_LSB = 75;
    localparam int CPL_STATUS_MSB = 77;
    localparam int CPL_DATA_LSB = 96;
    localparam int CPL_DATA_MSB = 127;

    // Successful completion status code
    localparam logic [2:0] CPL_STATUS_SC = 3'b000;

    localparam logic [31:0] CORE_ID = 32'h5043_4531;

    typedef enum logic [3:0] {
        MEM_READ  = 4'b0000,
        MEM_WRITE = 4'b0001
    } req_type_t;

    typedef enum logic [1:0] {
        IDLE,
        PAYLOAD,
        DROP
    } cq_state_t;

    // Byte offsets inside BAR0, one register per dword
    typedef enum logic [REG_ADDR_WIDTH-1:0] {
        REG_ID          = 16'h0000,
        REG_SCRATCH     = 16'h0004,
        REG_LED         = 16'h0008,
        REG_SWITCH      = 16'h000C,
        REG_WRITE_COUNT = 16'h0010
    } reg_offset_t;

endpackage

`default_nettype wire
